// File: rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

`define RV_XLEN          32
`define RV_NREG          32

`define RV_OP_LOAD       7'b0000011
`define RV_OP_STORE      7'b0100011
`define RV_OP_BRANCH     7'b1100011
`define RV_OP_JAL        7'b1101111
`define RV_OP_JALR       7'b1100111
`define RV_OP_OPIMM      7'b0010011
`define RV_OP_OP         7'b0110011
`define RV_OP_LUI        7'b0110111
`define RV_OP_AUIPC      7'b0010111

`define RV_FUNCT7_MULDIV 7'b0000001

`endif

// File: rv_pkg.sv
`include "rv_settings.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_MUL,
        ALU_MULH,
        ALU_MULHSU,
        ALU_MULHU,
        ALU_PASSB                                        // lui
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_ALWAYS
    } br_cond_e;

    typedef enum logic [1:0] {
        WB_ALU, WB_LOAD, WB_DIV, WB_PC4
    } wb_src_e;

    typedef enum logic [1:0] {
        SZ_B, SZ_H, SZ_W                                 // same code as funct3[1:0]
    } mem_size_e;

    typedef struct packed {
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        alu_op_e    alu_op;
        br_cond_e   br_cond;
        wb_src_e    wb_src;
        logic       reg_write;
        logic       use_imm;                             // operand b is the immediate
        logic       use_pc;                              // operand a is the pc
        logic       mem_read;
        logic       mem_write;
        mem_size_e  mem_size;
        logic       mem_unsigned;
        logic       div_start;
        logic       div_signed;
        logic       div_rem;                             // remainder, not quotient
        logic       jalr;
    } ctrl_t;

    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        word_t      adr;
        word_t      dat;
        logic [3:0] sel;
    } wb_req_t;

    typedef struct packed {
        word_t dat;
        logic  ack;
    } wb_rsp_t;

endpackage

// File: rv_decoder.sv
`include "rv_settings.svh"

module rv_decoder
    import rv_pkg::*;
(
    input  word_t i_inst,
    output ctrl_t o_ctrl,
    output word_t o_imm
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;

    assign opcode = i_inst[6:0];
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];

    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign imm_b = {{20{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign imm_u = {i_inst[31:12], 12'h000};
    assign imm_j = {{12{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

    // shared by op and op-imm, alt picks sub / sra
    function automatic alu_op_e base_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic br_cond_e branch_cond(input logic [2:0] f3);
        case (f3)
            3'b000:  return BR_EQ;
            3'b001:  return BR_NE;
            3'b100:  return BR_LT;
            3'b101:  return BR_GE;
            3'b110:  return BR_LTU;
            3'b111:  return BR_GEU;
            default: return BR_NONE;                     // 010 and 011 are reserved
        endcase
    endfunction

    always_comb begin
        o_ctrl     = '0;
        o_ctrl.rs1 = i_inst[19:15];
        o_ctrl.rs2 = i_inst[24:20];
        o_ctrl.rd  = i_inst[11:7];
        o_imm      = imm_i;
        case (opcode)
            `RV_OP_LUI: begin
                o_ctrl.alu_op    = ALU_PASSB;
                o_ctrl.use_imm   = 1'b1;
                o_ctrl.reg_write = 1'b1;
                o_imm            = imm_u;
            end
            `RV_OP_AUIPC: begin
                o_ctrl.use_pc    = 1'b1;
                o_ctrl.use_imm   = 1'b1;
                o_ctrl.reg_write = 1'b1;
                o_imm            = imm_u;
            end
            `RV_OP_JAL: begin
                o_ctrl.use_pc    = 1'b1;                 // alu forms the target
                o_ctrl.use_imm   = 1'b1;
                o_ctrl.br_cond   = BR_ALWAYS;
                o_ctrl.wb_src    = WB_PC4;
                o_ctrl.reg_write = 1'b1;
                o_imm            = imm_j;
            end
            `RV_OP_JALR: begin
                if (funct3 == 3'b000) begin
                    o_ctrl.use_imm   = 1'b1;
                    o_ctrl.br_cond   = BR_ALWAYS;
                    o_ctrl.jalr      = 1'b1;
                    o_ctrl.wb_src    = WB_PC4;
                    o_ctrl.reg_write = 1'b1;
                end
            end
            `RV_OP_BRANCH: begin
                o_ctrl.use_pc  = 1'b1;
                o_ctrl.use_imm = 1'b1;
                o_ctrl.br_cond = branch_cond(funct3);
                o_imm          = imm_b;
            end
            `RV_OP_LOAD: begin
                if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
                    o_ctrl.use_imm      = 1'b1;
                    o_ctrl.mem_read     = 1'b1;
                    o_ctrl.mem_size     = mem_size_e'(funct3[1:0]);
                    o_ctrl.mem_unsigned = funct3[2];
                    o_ctrl.wb_src       = WB_LOAD;
                    o_ctrl.reg_write    = 1'b1;
                end
            end
            `RV_OP_STORE: begin
                if (funct3 inside {3'b000, 3'b001, 3'b010}) begin
                    o_ctrl.use_imm   = 1'b1;
                    o_ctrl.mem_write = 1'b1;
                    o_ctrl.mem_size  = mem_size_e'(funct3[1:0]);
                end
                o_imm = imm_s;
            end
            `RV_OP_OPIMM: begin
                o_ctrl.use_imm = 1'b1;
                o_ctrl.alu_op  = base_op(funct3, funct3 == 3'b101 && funct7[5]);
                if (funct3 == 3'b001) begin
                    o_ctrl.reg_write = (funct7 == 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    o_ctrl.reg_write = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                end else begin
                    o_ctrl.reg_write = 1'b1;
                end
            end
            `RV_OP_OP: begin
                if (funct7 == `RV_FUNCT7_MULDIV) begin
                    o_ctrl.reg_write = 1'b1;
                    if (funct3[2]) begin
                        o_ctrl.div_start  = 1'b1;
                        o_ctrl.div_signed = ~funct3[0];
                        o_ctrl.div_rem    = funct3[1];
                        o_ctrl.wb_src     = WB_DIV;
                    end else begin
                        case (funct3[1:0])
                            2'b00:   o_ctrl.alu_op = ALU_MUL;
                            2'b01:   o_ctrl.alu_op = ALU_MULH;
                            2'b10:   o_ctrl.alu_op = ALU_MULHSU;
                            default: o_ctrl.alu_op = ALU_MULHU;
                        endcase
                    end
                end else if (funct7 == 7'b0000000 ||
                             (funct7 == 7'b0100000 && funct3 inside {3'b000, 3'b101})) begin
                    o_ctrl.alu_op    = base_op(funct3, funct7[5]);
                    o_ctrl.reg_write = 1'b1;
                end
            end
            default: ;                                   // unknown opcode runs as a nop
        endcase
    end

endmodule

// File: rv_regfile.sv
`include "rv_settings.svh"

module rv_regfile
    import rv_pkg::*;
(
    input  logic       clk,
    input  logic       clrn,
    input  logic [4:0] i_rs1,
    input  logic [4:0] i_rs2,
    input  logic [4:0] i_rd,
    input  logic       i_we,
    input  word_t      i_wdata,
    output word_t      o_rdata1,
    output word_t      o_rdata2
);
    word_t regs [1:`RV_NREG-1];                          // x0 has no storage

    assign o_rdata1 = (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
    assign o_rdata2 = (i_rs2 == 5'd0) ? '0 : regs[i_rs2];

    always_ff @(posedge clk or negedge clrn) begin
        if (!clrn) begin
            for (int i = 1; i < `RV_NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_rd != 5'd0) begin
            regs[i_rd] <= i_wdata;
        end
    end

endmodule

// File: rv_alu.sv
module rv_alu
    import rv_pkg::*;
(
    input  alu_op_e  i_op,
    input  br_cond_e i_cond,
    input  word_t    i_a,
    input  word_t    i_b,
    input  word_t    i_rs1,
    input  word_t    i_rs2,
    output word_t    o_result,
    output logic     o_taken
);
    logic               a_sgn, b_sgn;
    logic signed [32:0] a_m, b_m;
    logic signed [65:0] prod;
    logic               eq, lt, ltu;

    // one 33x33 signed multiplier covers all four forms
    assign a_sgn = (i_op == ALU_MULH) || (i_op == ALU_MULHSU);
    assign b_sgn = (i_op == ALU_MULH);
    assign a_m   = {a_sgn & i_a[31], i_a};
    assign b_m   = {b_sgn & i_b[31], i_b};
    assign prod  = a_m * b_m;

    always_comb begin
        case (i_op)
            ALU_SUB:    o_result = i_a - i_b;
            ALU_AND:    o_result = i_a & i_b;
            ALU_OR:     o_result = i_a | i_b;
            ALU_XOR:    o_result = i_a ^ i_b;
            ALU_SLL:    o_result = i_a << i_b[4:0];
            ALU_SRL:    o_result = i_a >> i_b[4:0];
            ALU_SRA:    o_result = $signed(i_a) >>> i_b[4:0];
            ALU_SLT:    o_result = {31'd0, $signed(i_a) < $signed(i_b)};
            ALU_SLTU:   o_result = {31'd0, i_a < i_b};
            ALU_MUL:    o_result = prod[31:0];
            ALU_MULH,
            ALU_MULHSU,
            ALU_MULHU:  o_result = prod[63:32];      // upper half
            ALU_PASSB:  o_result = i_b;
            default:    o_result = i_a + i_b;        // add, also addresses and targets
        endcase
    end

    // compare on the raw source registers, not the selected operands
    assign eq  = (i_rs1 == i_rs2);
    assign lt  = $signed(i_rs1) < $signed(i_rs2);
    assign ltu = i_rs1 < i_rs2;

    always_comb begin
        case (i_cond)
            BR_EQ:     o_taken = eq;
            BR_NE:     o_taken = ~eq;
            BR_LT:     o_taken = lt;
            BR_GE:     o_taken = ~lt;
            BR_LTU:    o_taken = ltu;
            BR_GEU:    o_taken = ~ltu;
            BR_ALWAYS: o_taken = 1'b1;
            default:   o_taken = 1'b0;
        endcase
    end

endmodule

// File: rv_divider.sv
module rv_divider
    import rv_pkg::*;
(
    input  logic  clk,
    input  logic  clrn,
    input  logic  i_start,
    input  logic  i_signed,
    input  logic  i_rem,
    input  word_t i_dividend,
    input  word_t i_divisor,
    output logic  o_busy,
    output word_t o_result
);
    typedef enum logic [1:0] {DV_IDLE, DV_RUN, DV_DONE} dv_state_e;

    dv_state_e   state;
    logic [4:0]  step;
    word_t       quo, rem, dvs;
    logic        neg_q, neg_r, want_rem;
    logic        load;
    logic [32:0] trial;

    assign load   = (state != DV_RUN) && i_start;
    assign o_busy = (state == DV_RUN) || load;
    assign trial  = {rem, quo[31]} - {1'b0, dvs};       // shift in next dividend bit

    always_ff @(posedge clk or negedge clrn) begin
        if (!clrn) begin
            state <= DV_IDLE;
            step  <= '0;
        end else if (load) begin
            state <= DV_RUN;
            step  <= '0;
        end else if (state == DV_RUN) begin
            step <= step + 5'd1;
            if (step == 5'd31) begin
                state <= DV_DONE;                        // result valid for one cycle
            end
        end else begin
            state <= DV_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            quo      <= (i_signed && i_dividend[31]) ? -i_dividend : i_dividend;
            dvs      <= (i_signed && i_divisor[31]) ? -i_divisor : i_divisor;
            rem      <= '0;
            neg_q    <= i_signed && (i_dividend[31] ^ i_divisor[31]) && (i_divisor != '0);
            neg_r    <= i_signed && i_dividend[31];  // remainder takes dividend sign
            want_rem <= i_rem;
        end else if (state == DV_RUN) begin
            if (!trial[32]) begin
                rem <= trial[31:0];
                quo <= {quo[30:0], 1'b1};
            end else begin
                rem <= {rem[30:0], quo[31]};         // restore
                quo <= {quo[30:0], 1'b0};
            end
        end
    end

    // divide by zero falls out as all ones and the dividend
    assign o_result = want_rem ? (neg_r ? -rem : rem) : (neg_q ? -quo : quo);

endmodule

// File: rv_lsu.sv
module rv_lsu
    import rv_pkg::*;
(
    input  logic       clk,
    input  logic       clrn,
    input  logic       i_read,
    input  logic       i_write,
    input  logic       i_unsigned,
    input  logic [1:0] i_size,
    input  word_t      i_addr,
    input  word_t      i_wdata,
    output wb_req_t    o_wb,
    input  wb_rsp_t    i_wb,
    output logic       o_busy,
    output word_t      o_rdata
);
    logic       gap;                                     // idle cycle after ack
    logic       active;
    logic [3:0] sel;
    word_t      lanes;
    logic [4:0] lane_sh;
    word_t      lane;

    assign active = (i_read || i_write) && !gap;
    assign o_busy = (i_read || i_write) && !(active && i_wb.ack);

    always_ff @(posedge clk or negedge clrn) begin
        if (!clrn) begin
            gap <= 1'b0;
        end else begin
            gap <= active && i_wb.ack;
        end
    end

    // byte lane steering for stores
    always_comb begin
        case (i_size)
            SZ_B: begin
                sel   = 4'b0001 << i_addr[1:0];
                lanes = {4{i_wdata[7:0]}};
            end
            SZ_H: begin
                sel   = 4'b0011 << {i_addr[1], 1'b0};
                lanes = {2{i_wdata[15:0]}};
            end
            default: begin
                sel   = 4'b1111;
                lanes = i_wdata;
            end
        endcase
    end

    always_comb begin
        o_wb.cyc = active;
        o_wb.stb = active;
        o_wb.we  = i_write;
        o_wb.adr = {i_addr[31:2], 2'b00};                // word address, lanes by sel
        o_wb.dat = lanes;
        o_wb.sel = sel;
    end

    assign lane_sh = (i_size == SZ_H) ? {i_addr[1], 4'b0000} : {i_addr[1:0], 3'b000};
    assign lane    = i_wb.dat >> lane_sh;

    always_comb begin
        case (i_size)
            SZ_B:    o_rdata = {{24{lane[7] & ~i_unsigned}}, lane[7:0]};
            SZ_H:    o_rdata = {{16{lane[15] & ~i_unsigned}}, lane[15:0]};
            default: o_rdata = i_wb.dat;
        endcase
    end

endmodule

// File: rv_core.sv
module rv_core
    import rv_pkg::*;
(
    input  logic    clk,
    input  logic    clrn,
    input  word_t   i_inst,
    output word_t   o_pc,
    output wb_req_t o_wb,
    input  wb_rsp_t i_wb
);
    ctrl_t ctrl;
    word_t imm, rs1_val, rs2_val, op_a, op_b;
    word_t alu_res, load_data, div_res, wb_data;
    word_t pc_plus4, next_pc;
    logic  taken, lsu_busy, div_busy;
    logic  div_seen;                                     // current div already launched
    logic  div_go, advance;

    assign advance  = !lsu_busy && !div_busy;
    assign div_go   = ctrl.div_start && !div_seen;
    assign op_a     = ctrl.use_pc ? o_pc : rs1_val;
    assign op_b     = ctrl.use_imm ? imm : rs2_val;
    assign pc_plus4 = o_pc + 32'd4;

    always_comb begin
        if (!taken) begin
            next_pc = pc_plus4;
        end else if (ctrl.jalr) begin
            next_pc = {alu_res[31:1], 1'b0};
        end else begin
            next_pc = alu_res;                           // pc + branch or jal offset
        end
    end

    always_comb begin
        case (ctrl.wb_src)
            WB_LOAD: wb_data = load_data;
            WB_DIV:  wb_data = div_res;
            WB_PC4:  wb_data = pc_plus4;
            default: wb_data = alu_res;
        endcase
    end

    always_ff @(posedge clk or negedge clrn) begin
        if (!clrn) begin
            o_pc     <= '0;
            div_seen <= 1'b0;
        end else if (advance) begin
            o_pc     <= next_pc;
            div_seen <= 1'b0;
        end else if (div_go) begin
            div_seen <= 1'b1;                            // blocks restart in done cycle
        end
    end

    rv_decoder dec0 (
        .i_inst (i_inst),
        .o_ctrl (ctrl),
        .o_imm  (imm)
    );

    rv_regfile rf0 (
        .clk      (clk),
        .clrn     (clrn),
        .i_rs1    (ctrl.rs1),
        .i_rs2    (ctrl.rs2),
        .i_rd     (ctrl.rd),
        .i_we     (ctrl.reg_write && advance),
        .i_wdata  (wb_data),
        .o_rdata1 (rs1_val),
        .o_rdata2 (rs2_val)
    );

    rv_alu alu0 (
        .i_op     (ctrl.alu_op),
        .i_cond   (ctrl.br_cond),
        .i_a      (op_a),
        .i_b      (op_b),
        .i_rs1    (rs1_val),
        .i_rs2    (rs2_val),
        .o_result (alu_res),
        .o_taken  (taken)
    );

    rv_divider div0 (
        .clk        (clk),
        .clrn       (clrn),
        .i_start    (div_go),
        .i_signed   (ctrl.div_signed),
        .i_rem      (ctrl.div_rem),
        .i_dividend (rs1_val),
        .i_divisor  (rs2_val),
        .o_busy     (div_busy),
        .o_result   (div_res)
    );

    rv_lsu lsu0 (
        .clk        (clk),
        .clrn       (clrn),
        .i_read     (ctrl.mem_read),
        .i_write    (ctrl.mem_write),
        .i_unsigned (ctrl.mem_unsigned),
        .i_size     (ctrl.mem_size),
        .i_addr     (alu_res),
        .i_wdata    (rs2_val),
        .o_wb       (o_wb),
        .i_wb       (i_wb),
        .o_busy     (lsu_busy),
        .o_rdata    (load_data)
    );

endmodule

// File: rv_sva.sv
module rv_sva
    import rv_pkg::*;
(
    input logic    clk,
    input logic    clrn,
    input wb_req_t i_wb_req,
    input wb_rsp_t i_wb_rsp,
    input word_t   i_pc,
    input logic    i_lsu_busy
);
    int fails = 0;                                       // assertion failures so far

    stb_needs_cyc: assert property (@(posedge clk) disable iff (!clrn)
        i_wb_req.stb |-> i_wb_req.cyc)
        else begin
            fails++;
            $error("wishbone stb high without cyc");
        end

    // classic cycle holds the request until the slave answers
    req_held: assert property (@(posedge clk) disable iff (!clrn)
        (i_wb_req.stb && !i_wb_rsp.ack) |=> (i_wb_req.stb && $stable(i_wb_req.adr) &&
            $stable(i_wb_req.dat) && $stable(i_wb_req.we) && $stable(i_wb_req.sel)))
        else begin
            fails++;
            $error("wishbone request changed before ack");
        end

    pc_held: assert property (@(posedge clk) disable iff (!clrn)
        i_lsu_busy |=> $stable(i_pc))
        else begin
            fails++;
            $error("pc moved while the lsu was busy");
        end

    sel_on_write: assert property (@(posedge clk) disable iff (!clrn)
        (i_wb_req.cyc && i_wb_req.we) |-> (i_wb_req.sel != 4'b0000))
        else begin
            fails++;
            $error("wishbone write with empty sel");
        end

endmodule

bind rv_core rv_sva sva0 (
    .clk        (clk),
    .clrn       (clrn),
    .i_wb_req   (o_wb),
    .i_wb_rsp   (i_wb),
    .i_pc       (o_pc),
    .i_lsu_busy (lsu_busy)
);

// File: tb_checker.sv
module tb_checker
    import rv_pkg::*;
(
    input  logic    clk,
    input  logic    clrn,
    input  word_t   i_pc,
    input  wb_req_t i_wb_req,
    input  wb_rsp_t i_wb_rsp,
    output logic    o_done,
    output int      o_errors,
    output int      o_tests,
    output int      o_tests_failed
);
    int         exp_test [$];
    word_t      exp_adr [$];
    logic [3:0] exp_sel [$];
    word_t      exp_dat [$];
    logic       exp_last [$];
    int         idx = 0;
    int         errors = 0;
    int         tests = 0;
    int         tests_failed = 0;
    int         test_errs = 0;
    int         test_stores = 0;
    logic       done = 1'b0;
    logic       started = 1'b0;
    logic       bus_seen = 1'b0;

    assign o_done         = done;
    assign o_errors       = errors;
    assign o_tests        = tests;
    assign o_tests_failed = tests_failed;

    task automatic add_expect(input int t, input word_t adr, input logic [3:0] sel,
                              input word_t dat);
        exp_test.push_back(t);
        exp_adr.push_back(adr);
        exp_sel.push_back(sel);
        exp_dat.push_back(dat);
        exp_last.push_back(1'b0);
    endtask

    // marks the newest record as the last store of its test
    task automatic end_test();
        if (exp_last.size() > 0) begin
            exp_last[exp_last.size()-1] = 1'b1;
        end
    endtask

    task automatic check_store();
        int t;
        if (idx >= exp_test.size()) begin
            $display("store to address %h with data %h arrived when no store was expected",
                     i_wb_req.adr, i_wb_req.dat);
            errors++;
            return;
        end
        t = exp_test[idx];
        test_stores++;
        if (i_wb_req.adr !== exp_adr[idx]) begin
            $display("[FAIL] test %0d wb.adr: got %h, expected %h", t, i_wb_req.adr,
                     exp_adr[idx]);
            test_errs++;
        end
        if (i_wb_req.sel !== exp_sel[idx]) begin
            $display("[FAIL] test %0d wb.sel: got %h, expected %h", t, i_wb_req.sel,
                     exp_sel[idx]);
            test_errs++;
        end
        if (i_wb_req.dat !== exp_dat[idx]) begin
            $display("[FAIL] test %0d wb.dat: got %h, expected %h", t, i_wb_req.dat,
                     exp_dat[idx]);
            test_errs++;
        end
        if (exp_last[idx]) begin                         // test complete
            tests++;
            if (test_errs == 0) begin
                $display("test %0d passed, %0d stores", t, test_stores);
            end else begin
                $display("test %0d failed, %0d mismatches", t, test_errs);
                tests_failed++;
                errors += test_errs;
            end
            test_errs   = 0;
            test_stores = 0;
        end
        idx++;
        if (idx == exp_test.size()) begin
            done = 1'b1;
        end
    endtask

    // samples on the edge since inputs change 10 units after it
    always @(posedge clk) begin
        if (clrn) begin
            if (!started) begin
                started = 1'b1;
                if (i_pc !== '0) begin
                    $display("first fetch after reset is at %h instead of address zero", i_pc);
                    errors++;
                end
            end
            if (i_wb_req.cyc && !bus_seen) begin
                bus_seen = 1'b1;
                if (!i_wb_req.we) begin
                    $display("a bus read happened before the first store");
                    errors++;
                end
            end
            if (i_wb_req.cyc && i_wb_req.stb && i_wb_req.we && i_wb_rsp.ack) begin
                check_store();
            end
        end
    end

endmodule

// File: tb_top.sv
module tb_top
    import rv_pkg::*;
();
    logic    clk;
    logic    clrn;
    word_t   inst = 32'h00000013;                        // nop until the rom answers
    word_t   pc;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp = '0;
    wb_req_t mem_req;
    logic    ack_next;
    word_t   rom [0:255];
    word_t   dmem [0:255];
    integer  seed = 96109;
    int      wait_left = 0;
    int      nwords = 0;
    int      cycles = 0;
    int      limit;
    logic    hung = 1'b0;
    logic    load_err = 1'b0;
    logic    done;
    int      errors, tests, tests_failed;

    rv_core dut0 (
        .clk    (clk),
        .clrn   (clrn),
        .i_inst (inst),
        .o_pc   (pc),
        .o_wb   (wb_req),
        .i_wb   (wb_rsp)
    );

    tb_checker chk0 (
        .clk            (clk),
        .clrn           (clrn),
        .i_pc           (pc),
        .i_wb_req       (wb_req),
        .i_wb_rsp       (wb_rsp),
        .o_done         (done),
        .o_errors       (errors),
        .o_tests        (tests),
        .o_tests_failed (tests_failed)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        #10;
        inst = rom[pc[9:2]];
    end

    // wishbone slave memory that decides on the edge and answers 10 units later
    always @(posedge clk) begin
        mem_req  = wb_req;
        ack_next = 1'b0;
        if (!clrn) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] = 32'h5A000000 ^ (word_t'(i) << 2);
            end
        end else if (mem_req.cyc && mem_req.stb && !wb_rsp.ack) begin
            if (wait_left == 0) begin
                wait_left = 1 + int'($unsigned($random(seed)) % 3);
            end
            wait_left--;
            ack_next = (wait_left == 0);
        end
        #10;
        wb_rsp.ack = ack_next;
        if (ack_next) begin
            if (mem_req.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (mem_req.sel[b]) begin
                        dmem[mem_req.adr[9:2]][8*b +: 8] = mem_req.dat[8*b +: 8];
                    end
                end
            end else begin
                wb_rsp.dat = dmem[mem_req.adr[9:2]];
            end
        end
    end

    task automatic load_vectors();
        integer           fd;
        integer           code;
        logic [63:0]      tag;
        logic [8*128-1:0] rest;
        word_t            a, w, d;
        logic [3:0]       s;
        int               t;
        fd = $fopen("rv_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open rv_vectors.txt");
            load_err = 1'b1;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %s", tag);
            if (code != 1) begin
                break;
            end
            if (tag == "#") begin
                code = $fgets(rest, fd);
            end else if (tag == "P") begin
                code = $fscanf(fd, "%h %h", a, w);
                rom[a[9:2]] = w;
                nwords++;
            end else if (tag == "E") begin
                code = $fscanf(fd, "%d %h %h %h", t, a, s, d);
                chk0.add_expect(t, a, s, d);
            end else if (tag == "T") begin
                code = $fscanf(fd, "%d", t);
                chk0.end_test();
            end else begin
                $display("unknown record in rv_vectors.txt");
                load_err = 1'b1;
            end
        end
        $fclose(fd);
    endtask

    initial begin
        clrn = 1'b0;
        for (int i = 0; i < 256; i++) begin
            rom[i] = 32'h00000013;
        end
        load_vectors();
        limit = 40 * nwords + 100;                       // no backward branches in the program
        repeat (4) @(posedge clk);
        #10 clrn = 1'b1;
        while (!done && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        hung = !done;
        repeat (2) @(posedge clk);
        if (hung) begin
            $display("timeout after %0d cycles, the core hangs at pc %h", cycles, pc);
        end
        $display("tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests, tests_failed, errors, dut0.sva0.fails);
        if (!hung && !load_err && errors == 0 && tests_failed == 0 &&
            dut0.sva0.fails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: rv_vectors.txt
# P address word : program rom contents
# E test address sel data : expected store in order, T test : end of that test
P 000 06400093
P 004 FF900113
P 008 002081B3
P 00C 10302023
P 010 40208233
P 014 10402223
P 018 001122B3
P 01C 00113333
P 020 10502423
P 024 10602623
P 028 405153B3
P 02C 01C15413
P 030 00409493
P 034 12345537
P 038 00001597
P 03C 10702823
P 040 10802A23
P 044 10902C23
P 048 10A02E23
P 04C 12B02023
P 050 00108463
P 054 12202823
P 058 00109463
P 05C 12102223
P 060 00114463
P 064 12202823
P 068 00115463
P 06C 00116463
P 070 00117463
P 074 12202823
P 078 0080066F
P 07C 12202823
P 080 12C02423
P 084 09100693
P 088 00068767
P 08C 12202823
P 090 12E02623
P 094 A1B2C7B7
P 098 3D478793
P 09C 14F00023
P 0A0 14F000A3
P 0A4 14F00123
P 0A8 14F001A3
P 0AC 14F01223
P 0B0 14F01323
P 0B4 14F02423
P 0B8 14B00803
P 0BC 14B04883
P 0C0 14A01903
P 0C4 14805983
P 0C8 14402A03
P 0CC 15002823
P 0D0 15102A23
P 0D4 15202C23
P 0D8 15302E23
P 0DC 17402023
P 0E0 02208AB3
P 0E4 02209B33
P 0E8 02112BB3
P 0EC 02113C33
P 0F0 0220CCB3
P 0F4 0220ED33
P 0F8 02115DB3
P 0FC 02117E33
P 100 0200CEB3
P 104 0200EF33
P 108 80000FB7
P 10C FFF00193
P 110 023FC233
P 114 023FE2B3
P 118 17502823
P 11C 17602A23
P 120 17702C23
P 124 17802E23
P 128 19902023
P 12C 19A02223
P 130 19B02423
P 134 19C02623
P 138 19D02823
P 13C 19E02A23
P 140 18402C23
P 144 18502E23
P 148 0000006F
# test 1 alu, shifts, compares, lui and auipc
E 1 00000100 F 0000005D
E 1 00000104 F 0000006B
E 1 00000108 F 00000001
E 1 0000010C F 00000000
E 1 00000110 F FFFFFFFC
E 1 00000114 F 0000000F
E 1 00000118 F 00000640
E 1 0000011C F 12345000
E 1 00000120 F 00001038
T 1
# test 2 branches and jumps, links are pc plus 4
E 2 00000124 F 00000064
E 2 00000128 F 0000007C
E 2 0000012C F 0000008C
T 2
# test 3 byte, half and word stores
E 3 00000140 1 D4D4D4D4
E 3 00000140 2 D4D4D4D4
E 3 00000140 4 D4D4D4D4
E 3 00000140 8 D4D4D4D4
E 3 00000144 3 C3D4C3D4
E 3 00000144 C C3D4C3D4
E 3 00000148 F A1B2C3D4
T 3
# test 4 loads with sign and zero extension
E 4 00000150 F FFFFFFA1
E 4 00000154 F 000000A1
E 4 00000158 F FFFFA1B2
E 4 0000015C F 0000C3D4
E 4 00000160 F C3D4C3D4
T 4
# test 5 multiply, divide, zero divisor and overflow
E 5 00000170 F FFFFFD44
E 5 00000174 F FFFFFFFF
E 5 00000178 F FFFFFFFF
E 5 0000017C F 00000063
E 5 00000180 F FFFFFFF2
E 5 00000184 F 00000002
E 5 00000188 F 028F5C28
E 5 0000018C F 00000059
E 5 00000190 F FFFFFFFF
E 5 00000194 F 00000064
E 5 00000198 F 80000000
E 5 0000019C F 00000000
T 5

// File: tb.f
+incdir+.
rv_pkg.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_divider.sv
rv_lsu.sv
rv_core.sv
rv_sva.sv
tb_checker.sv
tb_top.sv

// File: Makefile
TOP = tb_top

all: run

build:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o sim

run: build
	./obj_dir/sim | tee /dev/stderr | grep -qx "Everything OK"

lint:
	verilator --lint-only -Wall --timing -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
